// ==== rtl/mac_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// array geometry and memory line widths
// the 64-bit lines fix the array at 4x4 with 16-bit results
// changing DIM alone does not rescale the memory layout
////////////////////////////////////////////////////////////

package mac_cfg_pkg;

    // array side, also the largest T, N and M
    localparam int DIM = 4;

    // operand and accumulator widths
    localparam int ELEM_W = 8;
    localparam int ACC_W = 16;

    // memory line width, four operand bytes or four result fields
    localparam int LINE_W = 64;

    // input and weight address width
    localparam int IADDR_W = 3;

    // output address width
    localparam int OADDR_W = 4;

    // one size field of MNT
    localparam int SIZE_W = 4;

endpackage

// ==== rtl/mac_types_pkg.sv ====
////////////////////////////////////////////////////////////
// state encodings and the structs passed between stages
// lane and field index 0 sits at the most significant end
////////////////////////////////////////////////////////////

package mac_types_pkg;

    import mac_cfg_pkg::*;

    // job sizes, M in the top field and T in the bottom one
    typedef struct packed {
        logic [SIZE_W-1:0] m;
        logic [SIZE_W-1:0] n;
        logic [SIZE_W-1:0] t;
    } mnt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_FEED
    } ctrl_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_WRITE
    } wr_state_e;

    // one reduction step k: column k of I, row k of W
    typedef struct packed {
        logic                       valid;
        logic                       first;
        logic                       last;
        logic [SIZE_W-1:0]          rows;
        logic [0:DIM-1][ELEM_W-1:0] a_vec;
        logic [0:DIM-1][ELEM_W-1:0] b_vec;
    } operand_wave_t;

    // finished job, acc[t][j] is element (t,j) of O
    typedef struct packed {
        logic                                valid;
        logic [SIZE_W-1:0]                   rows;
        logic [0:DIM-1][0:DIM-1][ACC_W-1:0] acc;
    } result_block_t;

endpackage

// ==== rtl/mac_ctrl.sv ====
////////////////////////////////////////////////////////////
// loads I and W into row buffers, then feeds N waves
// START counts only in idle, MNT is sampled with it
// sizes outside 1..4 are not supported
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_ctrl (
    input  logic                              CLK,
    input  logic                              RSTN,
    input  mac_types_pkg::mnt_t               mnt,
    input  logic                              start,
    output logic                              en_i,
    output logic [mac_cfg_pkg::IADDR_W-1:0]   addr_i,
    input  logic [mac_cfg_pkg::LINE_W-1:0]    rdata_i,
    output logic                              en_w,
    output logic [mac_cfg_pkg::IADDR_W-1:0]   addr_w,
    input  logic [mac_cfg_pkg::LINE_W-1:0]    rdata_w,
    output mac_types_pkg::operand_wave_t      wave
);

    import mac_cfg_pkg::*;
    import mac_types_pkg::*;

    ctrl_state_e                         state;
    mnt_t                                mnt_q;
    logic [IADDR_W-1:0]                  cnt;
    logic [SIZE_W-1:0]                   load_len;
    logic                                feed_last;
    logic                                rd_i_q;
    logic                                rd_w_q;
    logic [IADDR_W-1:0]                  rd_addr_q;
    logic [0:DIM-1][0:DIM-1][ELEM_W-1:0] a_buf;
    logic [0:DIM-1][0:DIM-1][ELEM_W-1:0] b_buf;
    logic [0:DIM-1][ELEM_W-1:0]          w_row;

    // one extra load cycle lets the last read data land
    assign load_len = (mnt_q.t > mnt_q.n) ? mnt_q.t : mnt_q.n;
    assign feed_last = (cnt == mnt_q.n - 1'b1);

    assign en_i = (state == ST_LOAD) && (cnt < mnt_q.t);
    assign en_w = (state == ST_LOAD) && (cnt < mnt_q.n);
    assign addr_i = cnt;
    assign addr_w = cnt;

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state <= ST_IDLE;
            mnt_q <= '0;
            cnt <= '0;
            rd_i_q <= 1'b0;
            rd_w_q <= 1'b0;
            rd_addr_q <= '0;
        end else begin
            rd_i_q <= en_i;
            rd_w_q <= en_w;
            rd_addr_q <= cnt;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        mnt_q <= mnt;
                        cnt <= '0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (cnt == load_len) begin
                        cnt <= '0;
                        state <= ST_FEED;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_FEED: begin
                    if (feed_last) begin
                        cnt <= '0;
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // row buffers
    ////////////////////////////////////////////////////////////

    // weight columns j >= M become zero
    always_comb begin
        w_row = rdata_w[LINE_W-1 -: DIM*ELEM_W];
        for (int j = 0; j < DIM; j++) begin
            if (j >= mnt_q.m) begin
                w_row[j] = '0;
            end
        end
    end

    // unused rows stay zero from the clear at start
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && start) begin
            a_buf <= '0;
            b_buf <= '0;
        end else begin
            if (rd_i_q) begin
                a_buf[rd_addr_q] <= rdata_i[LINE_W-1 -: DIM*ELEM_W];
            end
            if (rd_w_q) begin
                b_buf[rd_addr_q] <= w_row;
            end
        end
    end

    // wave k carries column k of I and row k of W
    always_comb begin
        wave = '0;
        if (state == ST_FEED) begin
            wave.valid = 1'b1;
            wave.first = (cnt == '0);
            wave.last = feed_last;
            wave.rows = mnt_q.t;
            wave.b_vec = b_buf[cnt];
            for (int t = 0; t < DIM; t++) begin
                wave.a_vec[t] = a_buf[t][cnt];
            end
        end
    end

    a_size_ok: assert property (@(posedge CLK) disable iff (!RSTN)
        (start && state == ST_IDLE) |->
            (mnt.m inside {[1:DIM]}) && (mnt.n inside {[1:DIM]}) && (mnt.t inside {[1:DIM]}));

    // read data lands while the controller is still loading
    a_rd_in_load: assert property (@(posedge CLK) disable iff (!RSTN)
        (rd_i_q || rd_w_q) |-> (state == ST_LOAD));

endmodule

// ==== rtl/operand_skew.sv ====
////////////////////////////////////////////////////////////
// staggers a wave into a diagonal wavefront
// lane l is delayed l cycles, control follows lane 0
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module operand_skew (
    input  logic                         CLK,
    input  logic                         RSTN,
    input  mac_types_pkg::operand_wave_t wave_in,
    output mac_types_pkg::operand_wave_t wave_out
);

    import mac_cfg_pkg::*;

    logic [ELEM_W-1:0] a_lane [DIM];
    logic [ELEM_W-1:0] b_lane [DIM];

    for (genvar l = 0; l < DIM; l++) begin : g_lane
        if (l == 0) begin : g_pass
            assign a_lane[l] = wave_in.a_vec[l];
            assign b_lane[l] = wave_in.b_vec[l];
        end else begin : g_dly
            logic [ELEM_W-1:0] a_sr [l];
            logic [ELEM_W-1:0] b_sr [l];

            always_ff @(posedge CLK or negedge RSTN) begin
                if (!RSTN) begin
                    a_sr <= '{default: '0};
                    b_sr <= '{default: '0};
                end else begin
                    a_sr[0] <= wave_in.a_vec[l];
                    b_sr[0] <= wave_in.b_vec[l];
                    for (int n = 1; n < l; n++) begin
                        a_sr[n] <= a_sr[n-1];
                        b_sr[n] <= b_sr[n-1];
                    end
                end
            end

            assign a_lane[l] = a_sr[l-1];
            assign b_lane[l] = b_sr[l-1];
        end
    end

    always_comb begin
        wave_out = wave_in;
        for (int l = 0; l < DIM; l++) begin
            wave_out.a_vec[l] = a_lane[l];
            wave_out.b_vec[l] = b_lane[l];
        end
    end

endmodule

// ==== rtl/mac_pe.sv ====
////////////////////////////////////////////////////////////
// one multiply-accumulate cell
// sum wraps at 16 bits, first reloads it with the product
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_pe (
    input  logic                             CLK,
    input  logic                             RSTN,
    input  logic [mac_cfg_pkg::ELEM_W-1:0]   a_in,
    input  logic [mac_cfg_pkg::ELEM_W-1:0]   b_in,
    input  logic                             first_in,
    input  logic                             last_in,
    output logic [mac_cfg_pkg::ELEM_W-1:0]   a_out,
    output logic [mac_cfg_pkg::ELEM_W-1:0]   b_out,
    output logic                             first_out,
    output logic                             last_out,
    output logic [mac_cfg_pkg::ACC_W-1:0]    acc
);

    import mac_cfg_pkg::*;

    logic [ACC_W-1:0] prod;

    assign prod = a_in * b_in;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            first_out <= 1'b0;
            last_out <= 1'b0;
        end else begin
            first_out <= first_in;
            last_out <= last_in;
        end
    end

    // acc holds the full sum while last_out is high
    always_ff @(posedge CLK) begin
        a_out <= a_in;
        b_out <= b_in;
        acc <= first_in ? prod : acc + prod;
    end

endmodule

// ==== rtl/systolic_array.sv ====
////////////////////////////////////////////////////////////
// 4x4 output-stationary grid, a flows east, b flows south
// each sum is delayed so that all sixteen line up with the
// last marker leaving the corner cell
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module systolic_array (
    input  logic                         CLK,
    input  logic                         RSTN,
    input  mac_types_pkg::operand_wave_t wave,
    output mac_types_pkg::result_block_t result
);

    import mac_cfg_pkg::*;

    // edge columns of the buses carry the skewed lanes
    logic [ELEM_W-1:0] a_bus [DIM][DIM+1];
    logic [ELEM_W-1:0] b_bus [DIM+1][DIM];
    logic              first_in_w [DIM][DIM];
    logic              last_in_w [DIM][DIM];
    logic              first_out_w [DIM][DIM];
    logic              last_out_w [DIM][DIM];
    logic [ACC_W-1:0]  acc_w [DIM][DIM];
    logic [ACC_W-1:0]  res_acc [DIM][DIM];
    logic [SIZE_W-1:0] rows_sr [2*DIM-1];

    for (genvar l = 0; l < DIM; l++) begin : g_edge
        assign a_bus[l][0] = wave.a_vec[l];
        assign b_bus[0][l] = wave.b_vec[l];
    end

    for (genvar i = 0; i < DIM; i++) begin : g_row
        for (genvar j = 0; j < DIM; j++) begin : g_col
            localparam int DLY = 2*DIM - 2 - i - j;

            // markers enter at the corner, go down column 0, then east
            if (i == 0 && j == 0) begin : g_src
                assign first_in_w[i][j] = wave.valid & wave.first;
                assign last_in_w[i][j] = wave.valid & wave.last;
            end else if (j == 0) begin : g_down
                assign first_in_w[i][j] = first_out_w[i-1][0];
                assign last_in_w[i][j] = last_out_w[i-1][0];
            end else begin : g_east
                assign first_in_w[i][j] = first_out_w[i][j-1];
                assign last_in_w[i][j] = last_out_w[i][j-1];
            end

            mac_pe u_pe (
                .CLK       (CLK),
                .RSTN      (RSTN),
                .a_in      (a_bus[i][j]),
                .b_in      (b_bus[i][j]),
                .first_in  (first_in_w[i][j]),
                .last_in   (last_in_w[i][j]),
                .a_out     (a_bus[i][j+1]),
                .b_out     (b_bus[i+1][j]),
                .first_out (first_out_w[i][j]),
                .last_out  (last_out_w[i][j]),
                .acc       (acc_w[i][j])
            );

            // deskew, cell (i,j) finishes i+j cycles after the corner
            if (DLY == 0) begin : g_nodly
                assign res_acc[i][j] = acc_w[i][j];
            end else begin : g_dly
                logic [ACC_W-1:0] dly [DLY];

                always_ff @(posedge CLK) begin
                    dly[0] <= acc_w[i][j];
                    for (int n = 1; n < DLY; n++) begin
                        dly[n] <= dly[n-1];
                    end
                end

                assign res_acc[i][j] = dly[DLY-1];
            end
        end
    end

    // rows rides alongside the last marker
    always_ff @(posedge CLK) begin
        rows_sr[0] <= wave.rows;
        for (int n = 1; n < 2*DIM-1; n++) begin
            rows_sr[n] <= rows_sr[n-1];
        end
    end

    always_comb begin
        result.valid = last_out_w[DIM-1][DIM-1];
        result.rows = rows_sr[2*DIM-2];
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                result.acc[i][j] = res_acc[i][j];
            end
        end
    end

    // one last wave per job, and jobs are at least four cycles apart
    a_single_result: assert property (@(posedge CLK) disable iff (!RSTN)
        result.valid |=> !result.valid);

endmodule

// ==== rtl/result_writer.sv ====
////////////////////////////////////////////////////////////
// writes rows 0..T-1 of a result, one line per cycle
// a new result may arrive on the cycle of the last write
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module result_writer (
    input  logic                             CLK,
    input  logic                             RSTN,
    input  mac_types_pkg::result_block_t     result,
    output logic                             en_o,
    output logic                             rw_o,
    output logic [mac_cfg_pkg::OADDR_W-1:0]  addr_o,
    output logic [mac_cfg_pkg::LINE_W-1:0]   wdata_o,
    output logic                             done
);

    import mac_cfg_pkg::*;
    import mac_types_pkg::*;

    wr_state_e          state;
    result_block_t      blk;
    logic [OADDR_W-1:0] line;
    logic               last_line;

    assign last_line = (line == blk.rows - 1'b1);

    assign en_o = (state == WR_WRITE);
    assign rw_o = (state == WR_WRITE);
    assign addr_o = line;
    // field j of a row lands at the j-th 16 bits from the top
    assign wdata_o = blk.acc[line];

    always_ff @(posedge CLK) begin
        if (result.valid) begin
            blk <= result;
        end
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state <= WR_IDLE;
            line <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (result.valid) begin
                        line <= '0;
                        state <= WR_WRITE;
                    end
                end
                WR_WRITE: begin
                    if (last_line) begin
                        done <= 1'b1;
                        line <= '0;
                        if (!result.valid) begin
                            state <= WR_IDLE;
                        end
                    end else begin
                        line <= line + 1'b1;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    a_no_overrun: assert property (@(posedge CLK) disable iff (!RSTN)
        result.valid |-> (state == WR_IDLE) || last_line);

    // a block without rows would walk the whole output address range
    a_rows_in_range: assert property (@(posedge CLK) disable iff (!RSTN)
        result.valid |-> (result.rows inside {[1:DIM]}));

endmodule

// ==== rtl/macarray.sv ====
////////////////////////////////////////////////////////////
// 8-bit matrix multiplier O = I x W, sizes 1..4
// START pulse in, DONE pulse after the last output write
// memories answer one cycle after EN, never stall
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module macarray (
    input  logic                                  CLK,
    input  logic                                  RSTN,
    input  logic [3*mac_cfg_pkg::SIZE_W-1:0]      MNT,
    input  logic                                  START,
    output logic                                  EN_I,
    output logic [mac_cfg_pkg::IADDR_W-1:0]       ADDR_I,
    input  logic [mac_cfg_pkg::LINE_W-1:0]        RDATA_I,
    output logic                                  EN_W,
    output logic [mac_cfg_pkg::IADDR_W-1:0]       ADDR_W,
    input  logic [mac_cfg_pkg::LINE_W-1:0]        RDATA_W,
    output logic                                  EN_O,
    output logic                                  RW_O,
    output logic [mac_cfg_pkg::OADDR_W-1:0]       ADDR_O,
    output logic [mac_cfg_pkg::LINE_W-1:0]        WDATA_O,
    output logic                                  DONE
);

    import mac_types_pkg::*;

    operand_wave_t wave_raw;
    operand_wave_t wave_skew;
    result_block_t result;

    mac_ctrl u_ctrl (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .mnt     (MNT),
        .start   (START),
        .en_i    (EN_I),
        .addr_i  (ADDR_I),
        .rdata_i (RDATA_I),
        .en_w    (EN_W),
        .addr_w  (ADDR_W),
        .rdata_w (RDATA_W),
        .wave    (wave_raw)
    );

    operand_skew u_skew (
        .CLK      (CLK),
        .RSTN     (RSTN),
        .wave_in  (wave_raw),
        .wave_out (wave_skew)
    );

    systolic_array u_array (
        .CLK    (CLK),
        .RSTN   (RSTN),
        .wave   (wave_skew),
        .result (result)
    );

    result_writer u_writer (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .result  (result),
        .en_o    (EN_O),
        .rw_o    (RW_O),
        .addr_o  (ADDR_O),
        .wdata_o (WDATA_O),
        .done    (DONE)
    );

endmodule

// ==== verif/tb_sram_model.sv ====
////////////////////////////////////////////////////////////
// synchronous read memory, data valid one cycle after en
// the testbench sets the contents directly through mem
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sram_model (
    input  logic                            CLK,
    input  logic                            en,
    input  logic [mac_cfg_pkg::IADDR_W-1:0] addr,
    output logic [mac_cfg_pkg::LINE_W-1:0]  rdata
);

    import mac_cfg_pkg::*;

    logic [LINE_W-1:0] mem [2**IADDR_W];

    // every byte carries the whole line address
    initial begin
        rdata = '0;
        for (int a = 0; a < 2**IADDR_W; a++) begin
            mem[a] = {8{5'b10110, a[IADDR_W-1:0]}};
        end
    end

    always @(posedge CLK) begin
        if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== verif/tb_ref_model.svh ====
////////////////////////////////////////////////////////////
// expected output line for one row of O = I x W
// the including module must import mac_cfg_pkg first
// columns j >= m are zero, sums wrap at 16 bits
////////////////////////////////////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [LINE_W-1:0] expected_line(
    input logic [LINE_W-1:0]            in_line,
    input logic [0:DIM-1][LINE_W-1:0]   w_lines,
    input int                           n,
    input int                           m
);
    logic [LINE_W-1:0] row_out;
    logic [ACC_W-1:0]  sum;
    logic [ELEM_W-1:0] x;
    logic [ELEM_W-1:0] y;
    int                j;
    int                k;

    row_out = '0;
    for (j = 0; j < m; j++) begin
        sum = '0;
        for (k = 0; k < n; k++) begin
            // element k of the row, byte 0 at the top
            x = in_line[LINE_W-1-ELEM_W*k -: ELEM_W];
            y = w_lines[k][LINE_W-1-ELEM_W*j -: ELEM_W];
            // 16-bit context keeps the product whole and wraps the sum
            sum = sum + x * y;
        end
        row_out[LINE_W-1-ACC_W*j -: ACC_W] = sum;
    end
    return row_out;
endfunction

`endif

// ==== verif/tb_macarray.sv ====
////////////////////////////////////////////////////////////
// testbench for macarray, two memory models serve I and W
// output writes are checked in order against the reference
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_macarray;

    import mac_cfg_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DONE_TIMEOUT = 200;
    localparam int EN_TIMEOUT = 20;

    logic                CLK;
    logic                RSTN;
    logic [3*SIZE_W-1:0] MNT;
    logic                START;
    logic                EN_I;
    logic [IADDR_W-1:0]  ADDR_I;
    logic [LINE_W-1:0]   RDATA_I;
    logic                EN_W;
    logic [IADDR_W-1:0]  ADDR_W;
    logic [LINE_W-1:0]   RDATA_W;
    logic                EN_O;
    logic                RW_O;
    logic [OADDR_W-1:0]  ADDR_O;
    logic [LINE_W-1:0]   WDATA_O;
    logic                DONE;

    integer             seed;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    int                 write_count;
    int                 done_count;
    int                 err_base;
    int                 w_base;
    int                 d_base;
    logic [OADDR_W-1:0] cap_addr [$];
    logic [LINE_W-1:0]  cap_data [$];
    logic [OADDR_W-1:0] exp_addr [$];
    logic [LINE_W-1:0]  exp_data [$];
    logic [OADDR_W-1:0] got_a;
    logic [LINE_W-1:0]  got_d;
    logic [OADDR_W-1:0] want_a;
    logic [LINE_W-1:0]  want_d;

    `include "tb_ref_model.svh"

    macarray dut_i (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .MNT     (MNT),
        .START   (START),
        .EN_I    (EN_I),
        .ADDR_I  (ADDR_I),
        .RDATA_I (RDATA_I),
        .EN_W    (EN_W),
        .ADDR_W  (ADDR_W),
        .RDATA_W (RDATA_W),
        .EN_O    (EN_O),
        .RW_O    (RW_O),
        .ADDR_O  (ADDR_O),
        .WDATA_O (WDATA_O),
        .DONE    (DONE)
    );

    tb_sram_model imem (.CLK(CLK), .en(EN_I), .addr(ADDR_I), .rdata(RDATA_I));
    tb_sram_model wmem (.CLK(CLK), .en(EN_W), .addr(ADDR_W), .rdata(RDATA_W));

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD/2) CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////
    // output capture and compare
    ////////////////////////////////////////////////////////////

    // outputs change on the rising edge, so sample on the falling one
    always @(negedge CLK) begin
        if (RSTN && EN_O && RW_O) begin
            cap_addr.push_back(ADDR_O);
            cap_data.push_back(WDATA_O);
            write_count++;
        end
        if (RSTN && DONE) begin
            done_count++;
        end
    end

    // writes pair up with expected lines in issue order
    always @(negedge CLK) begin
        if (cap_addr.size() > 0) begin
            got_a = cap_addr.pop_front();
            got_d = cap_data.pop_front();
            if (exp_addr.size() == 0) begin
                $display("unexpected write to output line %0d at time %0t", got_a, $time);
                errors++;
            end else begin
                want_a = exp_addr.pop_front();
                want_d = exp_data.pop_front();
                if (got_a !== want_a || got_d !== want_d) begin
                    $display("[ERROR] %0t: line %0d data %h, expected line %0d data %h",
                        $time, got_a, got_d, want_a, want_d);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge CLK);
    endtask

    task automatic fill_random();
        for (int a = 0; a < 2**IADDR_W; a++) begin
            imem.mem[a] = {$random(seed), $random(seed)};
            wmem.mem[a] = {$random(seed), $random(seed)};
        end
    endtask

    task automatic fill_const(input logic [ELEM_W-1:0] v);
        for (int a = 0; a < 2**IADDR_W; a++) begin
            imem.mem[a] = {8{v}};
            wmem.mem[a] = {8{v}};
        end
    endtask

    // queue the expected rows, then pulse START for one cycle
    task automatic start_job(input logic [3:0] t, input logic [3:0] n, input logic [3:0] m);
        logic [0:DIM-1][LINE_W-1:0] w_lines;
        w_lines = {wmem.mem[0], wmem.mem[1], wmem.mem[2], wmem.mem[3]};
        for (int r = 0; r < t; r++) begin
            exp_addr.push_back(r);
            exp_data.push_back(expected_line(imem.mem[r], w_lines, n, m));
        end
        MNT = {m, n, t};
        START = 1'b1;
        @(negedge CLK);
        START = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < DONE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (done_count < target) begin
            $display("timeout at %0t: DONE never came within %0d cycles", $time, DONE_TIMEOUT);
            errors++;
        end
    endtask

    // returns on the first cycle with both read enables low again
    task automatic wait_reads_end();
        int cycles;
        cycles = 0;
        while (!(EN_I || EN_W) && cycles < EN_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        while ((EN_I || EN_W) && cycles < EN_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (cycles >= EN_TIMEOUT) begin
            $display("timeout at %0t: the memory reads of a job never finished", $time);
            errors++;
        end
    endtask

    task automatic begin_test();
        err_base = errors;
        w_base = write_count;
        d_base = done_count;
    endtask

    // long enough for a wrongly started job to show its writes
    task automatic check_counts(input int writes_exp, input int dones_exp);
        idle(30);
        if (write_count - w_base != writes_exp) begin
            $display("[ERROR] %0t: %0d output writes, expected %0d",
                $time, write_count - w_base, writes_exp);
            errors++;
        end
        if (done_count - d_base != dones_exp) begin
            $display("[ERROR] %0t: %0d DONE pulses, expected %0d",
                $time, done_count - d_base, dones_exp);
            errors++;
        end
        if (exp_addr.size() != 0) begin
            $display("%0d expected output writes never happened", exp_addr.size());
            errors++;
            exp_addr.delete();
            exp_data.delete();
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_base) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_base);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed = 61;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        write_count = 0;
        done_count = 0;
        RSTN = 1'b0;
        MNT = '0;
        START = 1'b0;
        repeat (5) @(negedge CLK);
        RSTN = 1'b1;

        begin_test();
        if (EN_I !== 1'b0 || EN_W !== 1'b0 || EN_O !== 1'b0 || RW_O !== 1'b0 ||
            DONE !== 1'b0) begin
            $display("[ERROR] %0t: after reset EN_I %b EN_W %b EN_O %b RW_O %b DONE %b, expected 0",
                $time, EN_I, EN_W, EN_O, RW_O, DONE);
            errors++;
        end
        idle(20);
        check_counts(0, 0);
        end_test("reset state");

        begin_test();
        fill_random();
        start_job(4, 4, 4);
        wait_done(d_base + 1);
        check_counts(4, 1);
        end_test("full 4x4x4 job");

        // 4 * 255 * 255 wraps past 16 bits
        begin_test();
        fill_const(8'hff);
        start_job(4, 4, 4);
        wait_done(d_base + 1);
        check_counts(4, 1);
        end_test("maximal operands");

        begin_test();
        fill_random();
        start_job(3, 2, 1);
        wait_done(d_base + 1);
        fill_random();
        start_job(1, 4, 3);
        wait_done(d_base + 2);
        check_counts(4, 2);
        end_test("uneven sizes");

        // second START on the first idle cycle after N=3 waves
        begin_test();
        fill_random();
        start_job(4, 3, 4);
        wait_reads_end();
        idle(3 + 1);
        fill_random();
        start_job(2, 4, 2);
        wait_done(d_base + 2);
        check_counts(6, 2);
        end_test("back-to-back jobs");

        begin_test();
        fill_random();
        start_job(4, 4, 4);
        idle(1);
        MNT = {4'd1, 4'd1, 4'd1};
        START = 1'b1;
        @(negedge CLK);
        START = 1'b0;
        wait_done(d_base + 1);
        check_counts(4, 1);
        end_test("ignored START");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verif
rtl/mac_cfg_pkg.sv
rtl/mac_types_pkg.sv
rtl/mac_ctrl.sv
rtl/operand_skew.sv
rtl/mac_pe.sv
rtl/systolic_array.sv
rtl/result_writer.sv
rtl/macarray.sv
verif/tb_sram_model.sv
verif/tb_macarray.sv
